/* files.f */
+incdir+test
src/valu_pkg.sv
src/valu_uop_pkg.sv
src/valu_sequencer.sv
src/credit_counter.sv
src/operand_prep.sv
src/valu_datapath.sv
src/valu_other_top.sv
test/tb_clock_gen.sv
test/tb_valu_other.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_valu_other > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_valu_other > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" sim.log; then
  exit 0
fi
exit 1

/* src/credit_counter.sv */
module credit_counter (
  input  logic clk,
  input  logic reset,
  input  logic spend,
  input  logic credit_return,
  output logic credit_avail
);

  valu_pkg::credit_t count;

  // a credit returned this cycle may be spent right away
  assign credit_avail = (count != '0) || credit_return;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= valu_pkg::credit_t'(valu_pkg::ROB_CREDITS);
    end else begin
      case ({spend, credit_return})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= valu_pkg::credit_t'(valu_pkg::ROB_CREDITS));

  a_spend_with_credit: assert property (@(posedge clk) disable iff (reset)
    spend |-> credit_avail);

endmodule

/* src/operand_prep.sv */
module operand_prep (
  input  valu_uop_pkg::valu_uop_t uop,
  output valu_pkg::vreg_t         src1,
  output valu_pkg::vreg_t         src2
);

  valu_pkg::xreg_t rs1;
  valu_pkg::vreg_t vs2;

  assign rs1 = uop.instr.rs1_data;
  assign vs2 = uop.instr.vs2_data;

  // scalar splat at the element width
  always_comb begin
    src1 = uop.instr.vs1_data;
    if (uop.instr.src_is_scalar) begin
      case (uop.instr.eew)
        valu_pkg::EEW8:  src1 = {(valu_pkg::VLEN / 8){rs1[7:0]}};
        valu_pkg::EEW16: src1 = {(valu_pkg::VLEN / 16){rs1[15:0]}};
        default:         src1 = {(valu_pkg::VLEN / valu_pkg::XLEN){rs1}};
      endcase
    end
  end

  // extension source slice lands in the low bits
  always_comb begin
    case (uop.instr.op)
      valu_uop_pkg::OP_ZEXT_VF2,
      valu_uop_pkg::OP_SEXT_VF2: begin
        src2 = valu_pkg::vreg_t'(vs2[uop.uop_index[0] * (valu_pkg::VLEN / 2)
                                     +: valu_pkg::VLEN / 2]);
      end
      valu_uop_pkg::OP_ZEXT_VF4,
      valu_uop_pkg::OP_SEXT_VF4: begin
        src2 = valu_pkg::vreg_t'(vs2[uop.uop_index * (valu_pkg::VLEN / 4)
                                     +: valu_pkg::VLEN / 4]);
      end
      default: begin
        src2 = vs2;
      end
    endcase
  end

endmodule

/* src/valu_datapath.sv */
module valu_datapath (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       issue_valid,
  input  valu_uop_pkg::valu_uop_t    uop,
  input  valu_pkg::vreg_t            src1,
  input  valu_pkg::vreg_t            src2,
  output logic                       result_valid,
  output valu_uop_pkg::valu_result_t result
);

  valu_uop_pkg::valu_op_e op;
  logic                   minmax_signed;
  logic                   is_max;
  logic                   ext_signed;
  valu_pkg::vmask_t       mask;
  valu_pkg::vreg_t [2:0]  minmax_w;
  valu_pkg::vreg_t [2:0]  merge_w;
  valu_pkg::vreg_t [2:0]  ext_k;
  valu_pkg::vreg_t        minmax_sel;
  valu_pkg::vreg_t        merge_sel;
  valu_pkg::vreg_t        result_data;

  assign op            = uop.instr.op;
  assign minmax_signed = (op == valu_uop_pkg::OP_MIN) || (op == valu_uop_pkg::OP_MAX);
  assign is_max        = (op == valu_uop_pkg::OP_MAXU) || (op == valu_uop_pkg::OP_MAX);
  assign ext_signed    = (op == valu_uop_pkg::OP_SEXT_VF2) || (op == valu_uop_pkg::OP_SEXT_VF4);
  assign mask          = uop.instr.v0_data[valu_pkg::VLENB-1:0];

  // min/max and merge per lane size where w indexes 8/16/32
  for (genvar w = 0; w < 3; w++) begin : g_lane
    localparam int EW = 8 << w;
    for (genvar e = 0; e < valu_pkg::VLEN / EW; e++) begin : g_elem
      logic [EW:0] a;
      logic [EW:0] b;
      logic        a_lt_b;

      // widen by one bit so one signed compare covers both forms
      assign a      = {minmax_signed & src2[e*EW+EW-1], src2[e*EW +: EW]};
      assign b      = {minmax_signed & src1[e*EW+EW-1], src1[e*EW +: EW]};
      assign a_lt_b = $signed(a) < $signed(b);

      assign minmax_w[w][e*EW +: EW] = (a_lt_b ^ is_max) ? src2[e*EW +: EW] : src1[e*EW +: EW];
      assign merge_w[w][e*EW +: EW]  = mask[e] ? src1[e*EW +: EW] : src2[e*EW +: EW];
    end
  end

  // k0 8->16, k1 16->32, k2 8->32
  for (genvar k = 0; k < 3; k++) begin : g_ext
    localparam int SW = (k == 1) ? 16 : 8;
    localparam int DW = (k == 0) ? 16 : 32;
    for (genvar e = 0; e < valu_pkg::VLEN / DW; e++) begin : g_elem
      assign ext_k[k][e*DW +: DW] = {{(DW - SW){ext_signed & src2[e*SW+SW-1]}},
                                     src2[e*SW +: SW]};
    end
  end

  always_comb begin
    case (uop.instr.eew)
      valu_pkg::EEW16: begin
        minmax_sel = minmax_w[1];
        merge_sel  = merge_w[1];
      end
      valu_pkg::EEW32: begin
        minmax_sel = minmax_w[2];
        merge_sel  = merge_w[2];
      end
      default: begin
        minmax_sel = minmax_w[0];
        merge_sel  = merge_w[0];
      end
    endcase
  end

  always_comb begin
    case (op)
      valu_uop_pkg::OP_MINU,
      valu_uop_pkg::OP_MIN,
      valu_uop_pkg::OP_MAXU,
      valu_uop_pkg::OP_MAX:      result_data = minmax_sel;
      valu_uop_pkg::OP_MERGE:    result_data = merge_sel;
      valu_uop_pkg::OP_MOVE:     result_data = src1;
      valu_uop_pkg::OP_ZEXT_VF2,
      valu_uop_pkg::OP_SEXT_VF2: begin
        result_data = (uop.instr.eew == valu_pkg::EEW8) ? ext_k[0] : ext_k[1];
      end
      valu_uop_pkg::OP_ZEXT_VF4,
      valu_uop_pkg::OP_SEXT_VF4: result_data = ext_k[2];
      default:                   result_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      result.rob_entry <= uop.instr.rob_entry;
      result.uop_index <= uop.uop_index;
      result.data      <= result_data;
    end
  end

  // uops of one instruction leave with rising uop_index
  a_uop_index_order: assert property (@(posedge clk) disable iff (reset)
    result_valid && $past(result_valid) && result.uop_index != '0
    |-> result.uop_index == $past(result.uop_index) + 1'b1);

endmodule

/* src/valu_other_top.sv */
module valu_other_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       instr_valid,
  input  valu_uop_pkg::valu_instr_t  instr,
  output logic                       instr_ready,
  output logic                       result_valid,
  output valu_uop_pkg::valu_result_t result,
  input  logic                       credit_return
);

  logic                    issue_valid;
  logic                    credit_avail;
  valu_uop_pkg::valu_uop_t issue_uop;
  valu_pkg::vreg_t         src1;
  valu_pkg::vreg_t         src2;

  valu_sequencer seq0 (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .credit_avail (credit_avail),
    .instr_ready  (instr_ready),
    .issue_valid  (issue_valid),
    .issue_uop    (issue_uop)
  );

  // every issued uop takes one ROB slot
  credit_counter credit0 (
    .clk           (clk),
    .reset         (reset),
    .spend         (issue_valid),
    .credit_return (credit_return),
    .credit_avail  (credit_avail)
  );

  operand_prep prep0 (
    .uop  (issue_uop),
    .src1 (src1),
    .src2 (src2)
  );

  valu_datapath dp0 (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .uop          (issue_uop),
    .src1         (src1),
    .src2         (src2),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

/* src/valu_pkg.sv */
package valu_pkg;

  // machine sizes
  localparam int VLEN            = 64;
  localparam int XLEN            = 32;
  localparam int VLENB           = VLEN / 8;

  // ROB interface
  localparam int ROB_CREDITS     = 4;
  localparam int ROB_DEPTH_WIDTH = 3;
  localparam int UOP_INDEX_WIDTH = 2;
  localparam int CREDIT_WIDTH    = $clog2(ROB_CREDITS + 1);

  // one vector register
  typedef logic [VLEN-1:0] vreg_t;

  // one scalar register
  typedef logic [XLEN-1:0] xreg_t;

  // one mask bit per byte lane
  typedef logic [VLENB-1:0] vmask_t;

  typedef logic [ROB_DEPTH_WIDTH-1:0] rob_entry_t;

  typedef logic [UOP_INDEX_WIDTH-1:0] uop_index_t;

  // holds 0 to ROB_CREDITS
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

  // element width, also used as a lane-size index
  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

endpackage

/* src/valu_sequencer.sv */
module valu_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      instr_valid,
  input  valu_uop_pkg::valu_instr_t instr,
  input  logic                      credit_avail,
  output logic                      instr_ready,
  output logic                      issue_valid,
  output valu_uop_pkg::valu_uop_t   issue_uop
);

  valu_uop_pkg::seq_state_e  state;
  valu_uop_pkg::valu_instr_t instr_q;
  valu_pkg::uop_index_t      uop_index;
  logic [2:0]                uop_count;
  logic                      last_uop;

  // zero means an illegal source width for the extension
  function automatic logic [2:0] count_uops(valu_uop_pkg::valu_op_e op,
                                            valu_pkg::eew_e eew);
    case (op)
      valu_uop_pkg::OP_ZEXT_VF2,
      valu_uop_pkg::OP_SEXT_VF2: return (eew == valu_pkg::EEW32) ? 3'd0 : 3'd2;
      valu_uop_pkg::OP_ZEXT_VF4,
      valu_uop_pkg::OP_SEXT_VF4: return (eew == valu_pkg::EEW8) ? 3'd4 : 3'd0;
      default:                   return 3'd1;
    endcase
  endfunction

  assign uop_count   = count_uops(instr_q.op, instr_q.eew);
  assign last_uop    = ({1'b0, uop_index} == uop_count - 3'd1);
  assign instr_ready = (state == valu_uop_pkg::S_IDLE);
  assign issue_valid = (state == valu_uop_pkg::S_ISSUE) && (uop_count != 3'd0) && credit_avail;

  assign issue_uop.instr     = instr_q;
  assign issue_uop.uop_index = uop_index;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= valu_uop_pkg::S_IDLE;
      uop_index <= '0;
    end else begin
      case (state)
        valu_uop_pkg::S_IDLE: begin
          if (instr_valid) begin
            state <= valu_uop_pkg::S_ISSUE;
          end
        end
        valu_uop_pkg::S_ISSUE: begin
          if (uop_count == 3'd0) begin
            state <= valu_uop_pkg::S_IDLE;
          end else if (issue_valid) begin
            if (last_uop) begin
              state     <= valu_uop_pkg::S_IDLE;
              uop_index <= '0;
            end else begin
              uop_index <= uop_index + 1'b1;
            end
          end
        end
        default: state <= valu_uop_pkg::S_IDLE;
      endcase
    end
  end

  // instruction held for the whole issue sequence
  always_ff @(posedge clk) begin
    if (instr_valid && instr_ready) begin
      instr_q <= instr;
    end
  end

  // a new instruction always starts at uop 0
  a_idle_index_zero: assert property (@(posedge clk) disable iff (reset)
    state == valu_uop_pkg::S_IDLE |-> uop_index == '0);

endmodule

/* src/valu_uop_pkg.sv */
package valu_uop_pkg;

  typedef enum logic [3:0] {
    OP_MINU     = 4'd0,
    OP_MIN      = 4'd1,
    OP_MAXU     = 4'd2,
    OP_MAX      = 4'd3,
    OP_MERGE    = 4'd4,
    OP_MOVE     = 4'd5,
    OP_ZEXT_VF2 = 4'd6,
    OP_SEXT_VF2 = 4'd7,
    OP_ZEXT_VF4 = 4'd8,
    OP_SEXT_VF4 = 4'd9
  } valu_op_e;

  typedef enum logic {
    S_IDLE  = 1'b0,
    S_ISSUE = 1'b1
  } seq_state_e;

  // for extensions eew is the source width
  typedef struct packed {
    valu_op_e              op;
    valu_pkg::eew_e        eew;
    logic                  src_is_scalar;
    valu_pkg::vreg_t       vs1_data;
    valu_pkg::xreg_t       rs1_data;
    valu_pkg::vreg_t       vs2_data;
    valu_pkg::vreg_t       v0_data;
    valu_pkg::rob_entry_t  rob_entry;
  } valu_instr_t;

  typedef struct packed {
    valu_instr_t           instr;
    valu_pkg::uop_index_t  uop_index;
  } valu_uop_t;

  typedef struct packed {
    valu_pkg::rob_entry_t  rob_entry;
    valu_pkg::uop_index_t  uop_index;
    valu_pkg::vreg_t       data;
  } valu_result_t;

endpackage

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // reset spans two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

/* test/tb_vectors.svh */
// add_row: op, eew, src_is_scalar, vs1, rs1, vs2, v0
// add_expect: uop count, then the results of uop 0 to 3

localparam int NUM_ROWS = 20;
localparam valu_pkg::vreg_t VS1_A = 64'h0180_8000_1000_0001;
localparam valu_pkg::vreg_t VS2_A = 64'h8001_7fff_0010_ff80;
localparam valu_pkg::vreg_t VS2_E = 64'h89ab_cdef_0123_4567;
localparam valu_pkg::vreg_t ZERO  = '0;

valu_uop_pkg::valu_instr_t row_instr [NUM_ROWS];
int                        row_count [NUM_ROWS];
valu_pkg::vreg_t           row_exp   [NUM_ROWS][4];
int                        rows_loaded;

task automatic load_vectors();
  // min/max, vector-vector
  add_row(valu_uop_pkg::OP_MIN, valu_pkg::EEW8, 1'b0, VS1_A, 32'h0, VS2_A, ZERO);
  add_expect(1, 64'h8080_80ff_0000_ff80, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MINU, valu_pkg::EEW8, 1'b0, VS1_A, 32'h0, VS2_A, ZERO);
  add_expect(1, 64'h0101_7f00_0000_0001, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MAX, valu_pkg::EEW16, 1'b0, VS1_A, 32'h0, VS2_A, ZERO);
  add_expect(1, 64'h0180_7fff_1000_0001, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MAXU, valu_pkg::EEW16, 1'b0, VS1_A, 32'h0, VS2_A, ZERO);
  add_expect(1, 64'h8001_8000_1000_ff80, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MIN, valu_pkg::EEW32, 1'b0, VS1_A, 32'h0, VS2_A, ZERO);
  add_expect(1, 64'h8001_7fff_0010_ff80, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MAXU, valu_pkg::EEW32, 1'b0, VS1_A, 32'h0, VS2_A, ZERO);
  add_expect(1, 64'h8001_7fff_1000_0001, ZERO, ZERO, ZERO);
  // min/max, vector-scalar
  add_row(valu_uop_pkg::OP_MAX, valu_pkg::EEW8, 1'b1, ZERO, 32'h0000_0005, VS2_A, ZERO);
  add_expect(1, 64'h0505_7f05_0510_0505, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MINU, valu_pkg::EEW16, 1'b1, ZERO, 32'hdead_1000, VS2_A, ZERO);
  add_expect(1, 64'h1000_1000_0010_1000, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MAX, valu_pkg::EEW32, 1'b1, ZERO, 32'hffff_fff0, VS2_A, ZERO);
  add_expect(1, 64'hffff_fff0_0010_ff80, ZERO, ZERO, ZERO);
  // merge and move
  add_row(valu_uop_pkg::OP_MERGE, valu_pkg::EEW8, 1'b0, VS1_A, 32'h0, VS2_A, 64'ha5);
  add_expect(1, 64'h0101_80ff_0000_ff01, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MERGE, valu_pkg::EEW16, 1'b0, VS1_A, 32'h0, VS2_A, ~64'h6);
  add_expect(1, 64'h0180_7fff_0010_0001, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MERGE, valu_pkg::EEW32, 1'b1, ZERO, 32'hcafe_f00d, VS2_A, 64'h2);
  add_expect(1, 64'hcafe_f00d_0010_ff80, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_MOVE, valu_pkg::EEW16, 1'b1, ZERO, 32'h1234_beef, ZERO, ZERO);
  add_expect(1, 64'hbeef_beef_beef_beef, ZERO, ZERO, ZERO);
  // extensions, illegal widths issue nothing
  add_row(valu_uop_pkg::OP_ZEXT_VF2, valu_pkg::EEW8, 1'b0, ZERO, 32'h0, VS2_E, ZERO);
  add_expect(2, 64'h0001_0023_0045_0067, 64'h0089_00ab_00cd_00ef, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_ZEXT_VF2, valu_pkg::EEW32, 1'b0, ZERO, 32'h0, VS2_E, ZERO);
  add_expect(0, ZERO, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_SEXT_VF2, valu_pkg::EEW8, 1'b0, ZERO, 32'h0, VS2_E, ZERO);
  add_expect(2, 64'h0001_0023_0045_0067, 64'hff89_ffab_ffcd_ffef, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_SEXT_VF2, valu_pkg::EEW16, 1'b0, ZERO, 32'h0, VS2_E, ZERO);
  add_expect(2, 64'h0000_0123_0000_4567, 64'hffff_89ab_ffff_cdef, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_SEXT_VF4, valu_pkg::EEW16, 1'b0, ZERO, 32'h0, VS2_E, ZERO);
  add_expect(0, ZERO, ZERO, ZERO, ZERO);
  add_row(valu_uop_pkg::OP_ZEXT_VF4, valu_pkg::EEW8, 1'b0, ZERO, 32'h0, VS2_E, ZERO);
  add_expect(4, 64'h0000_0045_0000_0067, 64'h0000_0001_0000_0023,
             64'h0000_00cd_0000_00ef, 64'h0000_0089_0000_00ab);
  add_row(valu_uop_pkg::OP_SEXT_VF4, valu_pkg::EEW8, 1'b0, ZERO, 32'h0, VS2_E, ZERO);
  add_expect(4, 64'h0000_0045_0000_0067, 64'h0000_0001_0000_0023,
             64'hffff_ffcd_ffff_ffef, 64'hffff_ff89_ffff_ffab);
endtask

/* test/tb_valu_other.sv */
module tb_valu_other;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD_NS = 8;
  localparam int DRIVE_DELAY   = 1;
  localparam int SEED          = 56;

  logic                       clk;
  logic                       reset;
  logic                       instr_valid;
  valu_uop_pkg::valu_instr_t  instr;
  logic                       instr_ready;
  logic                       result_valid;
  valu_uop_pkg::valu_result_t result;
  logic                       credit_return;

  valu_pkg::vreg_t      exp_data_q [$];
  valu_pkg::rob_entry_t exp_rob_q [$];
  valu_pkg::uop_index_t exp_idx_q [$];
  int unsigned          rob_arrival [$];
  int unsigned          rob_due [$];
  int unsigned          cycle;
  int                   outstanding;
  int                   results_seen;
  int                   mismatches;
  int                   protocol_errors;

  `include "tb_vectors.svh"

  localparam int WATCHDOG_CYCLES = NUM_ROWS * 4 * 12 + 200;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clock0 (.clk(clk), .reset(reset));

  valu_other_top dut0 (
    .clk           (clk),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .instr_ready   (instr_ready),
    .result_valid  (result_valid),
    .result        (result),
    .credit_return (credit_return)
  );

  task automatic add_row(input valu_uop_pkg::valu_op_e op, input valu_pkg::eew_e eew,
                         input logic scalar, input valu_pkg::vreg_t vs1,
                         input valu_pkg::xreg_t rs1, input valu_pkg::vreg_t vs2,
                         input valu_pkg::vreg_t v0);
    row_instr[rows_loaded] = '{op, eew, scalar, vs1, rs1, vs2, v0,
                               valu_pkg::rob_entry_t'(rows_loaded)};
  endtask

  task automatic add_expect(input int count, input valu_pkg::vreg_t e0,
                            input valu_pkg::vreg_t e1, input valu_pkg::vreg_t e2,
                            input valu_pkg::vreg_t e3);
    row_count[rows_loaded] = count;
    row_exp[rows_loaded]   = '{e0, e1, e2, e3};
    rows_loaded++;
  endtask

  task automatic check_data(input string name, input valu_pkg::vreg_t exp,
                            input valu_pkg::vreg_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_rob_entry(input string name, input valu_pkg::rob_entry_t exp,
                                 input valu_pkg::rob_entry_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_uop_index(input string name, input valu_pkg::uop_index_t exp,
                                 input valu_pkg::uop_index_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  // results and credit returns sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (result_valid) begin
        results_seen++;
        outstanding++;
        rob_arrival.push_back(cycle);
        if (exp_data_q.size() == 0) begin
          $display("extra result from the DUT for rob_entry %h", result.rob_entry);
          protocol_errors++;
        end else begin
          check_data("result.data", exp_data_q.pop_front(), result.data);
          check_rob_entry("result.rob_entry", exp_rob_q.pop_front(), result.rob_entry);
          check_uop_index("result.uop_index", exp_idx_q.pop_front(), result.uop_index);
        end
      end
      if (credit_return) begin
        outstanding--;
      end
      if (outstanding > valu_pkg::ROB_CREDITS) begin
        $display("more results in the ROB than it has credits: %0d", outstanding);
        protocol_errors++;
      end
    end
  end

  // ROB model returns one credit per cycle once its delay has run out
  initial begin
    void'($urandom(SEED));
    credit_return = 1'b0;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycle++;
      // each result gets its own delay of 0 to 5 cycles
      while (rob_arrival.size() != 0) begin
        rob_due.push_back(rob_arrival.pop_front() + $urandom_range(5, 0));
      end
      if (rob_due.size() != 0 && rob_due[0] <= cycle) begin
        void'(rob_due.pop_front());
        credit_return = 1'b1;
      end else begin
        credit_return = 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("timeout with %0d results still expected", exp_data_q.size());
    $display("Checks failed");
    $finish;
  end

  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    load_vectors();
    @(negedge clk);
    while (reset) @(negedge clk);
    check_flag("instr_ready", 1'b1, instr_ready);
    check_flag("result_valid", 1'b0, result_valid);
    @(posedge clk);
    #DRIVE_DELAY;
    for (int r = 0; r < rows_loaded; r++) begin
      instr_valid = 1'b1;
      instr       = row_instr[r];
      @(negedge clk);
      while (!instr_ready) @(negedge clk);
      for (int k = 0; k < row_count[r]; k++) begin
        exp_data_q.push_back(row_exp[r][k]);
        exp_rob_q.push_back(row_instr[r].rob_entry);
        exp_idx_q.push_back(valu_pkg::uop_index_t'(k));
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    instr_valid = 1'b0;
    while (exp_data_q.size() != 0 || outstanding != 0) @(negedge clk);
    // idle a while so that a stray result shows up
    repeat (10) @(negedge clk);
    $display("results %0d, mismatches %0d, protocol errors %0d",
             results_seen, mismatches, protocol_errors);
    if (mismatches + protocol_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
